//--- Makefile
TOP := tb_hart_uart_io

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f hart_uart_io.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir \
		-f hart_uart_io.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- cpu_pkg.sv
// cpu package: bus word type, bus opcodes, i/o register offsets and status bit positions
package cpu_pkg;

  localparam int XLEN   = 32;  // bus data width
  localparam int ADDR_W = 4;   // i/o register offset width

  typedef logic [XLEN-1:0] word;

  // opcode each hart port presents with its request
  typedef enum logic {
    bus_read  = 1'b0,
    bus_write = 1'b1
  } bus_op_e;

  localparam logic [ADDR_W-1:0] ADDR_TXDATA   = 4'h0;  // write pushes a word
  localparam logic [ADDR_W-1:0] ADDR_PRESCALE = 4'h4;  // baud shift
  localparam logic [ADDR_W-1:0] ADDR_STATUS   = 4'h8;  // read clears overflow

  localparam int STATUS_EMPTY    = 0;  // fifo has no words
  localparam int STATUS_FULL     = 1;
  localparam int STATUS_BUSY     = 2;  // transmitter mid-word
  localparam int STATUS_OVERFLOW = 3;  // sticky, a txdata write was dropped

endpackage

//--- hart_uart_io.f
cpu_pkg.sv
uart_pkg.sv
io_bus_arbiter.sv
uart_regs.sv
word_fifo.sv
uart_tx.sv
hart_uart_io.sv
uart_tx_asserts.sv
tb_hart_uart_io.sv

//--- hart_uart_io.sv
// hart_uart_io: console output top with bus arbiter, uart registers, word fifo and transmitter
`timescale 1ns/100ps

module hart_uart_io #(
  parameter int FIFO_DEPTH = 8,
  parameter int BASE_DIV   = 168,
  parameter int STOP_GAP   = 10
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       req0,
  input  cpu_pkg::bus_op_e           op0,
  input  logic [cpu_pkg::ADDR_W-1:0] addr0,
  input  cpu_pkg::word               wdata0,
  output logic                       gnt0,
  output cpu_pkg::word               rdata0,
  input  logic                       req1,
  input  cpu_pkg::bus_op_e           op1,
  input  logic [cpu_pkg::ADDR_W-1:0] addr1,
  input  cpu_pkg::word               wdata1,
  output logic                       gnt1,
  output cpu_pkg::word               rdata1,
  output logic                       tx
);

  logic                       bus_valid;
  cpu_pkg::bus_op_e           bus_op;
  logic [cpu_pkg::ADDR_W-1:0] bus_addr;
  cpu_pkg::word               bus_wdata;
  cpu_pkg::word               bus_rdata;
  logic                       push;
  cpu_pkg::word               push_data;
  logic                       pop;
  cpu_pkg::word               fifo_rdata;
  logic                       fifo_empty;
  logic                       fifo_full;
  logic                       tx_busy;
  cpu_pkg::word               prescale;

  io_bus_arbiter u_arb (
    .clk_i, .reset_i,
    .req0, .op0, .addr0, .wdata0, .gnt0, .rdata0,
    .req1, .op1, .addr1, .wdata1, .gnt1, .rdata1,
    .bus_valid, .bus_op, .bus_addr, .bus_wdata, .bus_rdata
  );

  uart_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_regs (
    .clk_i, .reset_i,
    .bus_valid, .bus_op, .bus_addr, .bus_wdata, .bus_rdata,
    .push, .push_data, .fifo_empty, .fifo_full, .tx_busy, .prescale
  );

  word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk_i, .reset_i,
    .push, .wdata(push_data), .pop, .rdata(fifo_rdata),
    .empty(fifo_empty), .full(fifo_full)
  );

  uart_tx #(.BASE_DIV(BASE_DIV), .STOP_GAP(STOP_GAP)) u_tx (
    .clk_i, .reset_i,
    .prescale, .fifo_rdata, .fifo_empty, .pop, .tx, .busy(tx_busy)
  );

endmodule

//--- io_bus_arbiter.sv
// io_bus_arbiter: round-robin arbiter sharing the i/o bus between two hart ports
`timescale 1ns/100ps

module io_bus_arbiter (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       req0,
  input  cpu_pkg::bus_op_e           op0,
  input  logic [cpu_pkg::ADDR_W-1:0] addr0,
  input  cpu_pkg::word               wdata0,
  output logic                       gnt0,
  output cpu_pkg::word               rdata0,
  input  logic                       req1,
  input  cpu_pkg::bus_op_e           op1,
  input  logic [cpu_pkg::ADDR_W-1:0] addr1,
  input  cpu_pkg::word               wdata1,
  output logic                       gnt1,
  output cpu_pkg::word               rdata1,
  output logic                       bus_valid,
  output cpu_pkg::bus_op_e           bus_op,
  output logic [cpu_pkg::ADDR_W-1:0] bus_addr,
  output cpu_pkg::word               bus_wdata,
  input  cpu_pkg::word               bus_rdata
);

  logic last_win;  // 1 when port 1 took the last transfer
  logic pick1;     // port 1 wins this cycle

  // on contention the port that lost last time goes first
  always_comb begin
    pick1 = req1 && (!req0 || !last_win);
  end

  assign bus_valid = req0 | req1;
  assign gnt0      = req0 && !pick1;
  assign gnt1      = pick1;

  always_comb begin
    if (pick1) begin
      bus_op    = op1;
      bus_addr  = addr1;
      bus_wdata = wdata1;
    end else begin
      bus_op    = op0;
      bus_addr  = addr0;
      bus_wdata = wdata0;
    end
  end

  assign rdata0 = bus_rdata;  // meaningful only with gnt0
  assign rdata1 = bus_rdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_win <= 1'b1;  // port 0 first out of reset
    end else if (bus_valid) begin
      last_win <= pick1;
    end
  end

endmodule

//--- tb_hart_uart_io.sv
// tb_hart_uart_io: table-driven testbench with bus drivers, tx line decoder, checks and report
`timescale 1ns/100ps

module tb_hart_uart_io;

  localparam int FIFO_DEPTH  = 4;
  localparam int BASE_DIV    = 4;
  localparam int STOP_GAP    = 1;
  localparam int ROWS        = 6;
  localparam int XFER_LIMIT  = 50;    // cycles a port waits for gnt
  localparam int START_LIMIT = 4000;  // cycles to wait for a first start bit
  localparam int IDLE_LIMIT  = 5000;  // status polls before giving up
  localparam int FRAME_BITS  = uart_pkg::DATA_BITS + 2 + STOP_GAP;  // start, data, stop, gap
  localparam cpu_pkg::word PSCALE_MASK = (32'd1 << uart_pkg::PRESCALE_W) - 32'd1;
  localparam cpu_pkg::word ST_EMPTY    = cpu_pkg::word'(1) << cpu_pkg::STATUS_EMPTY;
  localparam cpu_pkg::word ST_OVERFLOW = cpu_pkg::word'(1) << cpu_pkg::STATUS_OVERFLOW;

  logic                       clk_i;
  logic                       reset_i;
  logic                       req0, req1;
  cpu_pkg::bus_op_e           op0, op1;
  logic [cpu_pkg::ADDR_W-1:0] addr0, addr1;
  cpu_pkg::word               wdata0, wdata1;
  cpu_pkg::word               rdata0, rdata1;
  logic                       gnt0, gnt1;
  logic                       tx;

  // stimulus table, the decoded word must equal row_data
  int unsigned  row_port   [ROWS] = '{0, 1, 0, 1, 1, 0};
  int unsigned  row_pscale [ROWS] = '{0, 1, 2, 3, 0, 1};
  cpu_pkg::word row_data   [ROWS];  // filled from $random

  int           seed;
  int           errors = 0;
  int           checks = 0;
  int           tests  = 0;
  int           grant_log [$];  // port numbers in grant order
  cpu_pkg::word rx_log    [$];  // words decoded from tx

  hart_uart_io #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .BASE_DIV  (BASE_DIV),
    .STOP_GAP  (STOP_GAP)
  ) u_dut (
    .clk_i, .reset_i,
    .req0, .op0, .addr0, .wdata0, .gnt0, .rdata0,
    .req1, .op1, .addr1, .wdata1, .gnt1, .rdata1,
    .tx
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #4 clk_i = ~clk_i;
    end
  end

  task automatic compare_hex(input string name, input cpu_pkg::word expected,
                             input cpu_pkg::word actual);
    checks++;
    if (actual !== expected) begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d error(s)", name, errors - errors_before);
    end
  endtask

  task automatic reset_dut();
    reset_i = 1'b1;
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
  endtask

  task automatic align_to_drive_edge();
    @(posedge clk_i);
    #1;
  endtask

  // holds req and fields until gnt is seen, called and left 1 ns after a rising edge
  task automatic bus_xfer(input int port, input cpu_pkg::bus_op_e op,
                          input logic [cpu_pkg::ADDR_W-1:0] addr, input cpu_pkg::word wdata,
                          output cpu_pkg::word rdata);
    int   waited;
    logic granted;
    waited  = 0;
    granted = 1'b0;
    rdata   = '0;
    if (port == 0) begin
      req0   = 1'b1;
      op0    = op;
      addr0  = addr;
      wdata0 = wdata;
    end else begin
      req1   = 1'b1;
      op1    = op;
      addr1  = addr;
      wdata1 = wdata;
    end
    while (!granted && waited < XFER_LIMIT) begin
      @(negedge clk_i);  // gnt and rdata settled mid-cycle
      granted = (port == 0) ? gnt0 : gnt1;
      if (granted) begin
        rdata = (port == 0) ? rdata0 : rdata1;
        grant_log.push_back(port);
      end
      align_to_drive_edge();
      waited++;
    end
    if (port == 0) begin
      req0 = 1'b0;
    end else begin
      req1 = 1'b0;
    end
    if (!granted) begin
      $display("port %0d was not granted within %0d cycles", port, XFER_LIMIT);
      errors++;
    end
  endtask

  task automatic bus_write(input int port, input logic [cpu_pkg::ADDR_W-1:0] addr,
                           input cpu_pkg::word data);
    cpu_pkg::word ignored;
    bus_xfer(port, cpu_pkg::bus_write, addr, data, ignored);
  endtask

  task automatic bus_read(input int port, input logic [cpu_pkg::ADDR_W-1:0] addr,
                          output cpu_pkg::word data);
    bus_xfer(port, cpu_pkg::bus_read, addr, '0, data);
  endtask

  // polls status until the fifo is empty and the transmitter is done
  task automatic wait_idle(input int port);
    cpu_pkg::word status;
    int           polls;
    status = '0;
    polls  = 0;
    while ((status[cpu_pkg::STATUS_BUSY] || !status[cpu_pkg::STATUS_EMPTY]) &&
           polls < IDLE_LIMIT) begin
      bus_read(port, cpu_pkg::ADDR_STATUS, status);
      polls++;
    end
    if (status[cpu_pkg::STATUS_BUSY] || !status[cpu_pkg::STATUS_EMPTY]) begin
      $display("transmitter still busy after %0d status reads", IDLE_LIMIT);
      errors++;
    end
  endtask

  // negedges until tx is seen low, -1 on timeout
  task automatic wait_start_bit(input int limit, output int waited);
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < limit) begin
      @(negedge clk_i);
      waited++;
      seen = (tx === 1'b0);
    end
    if (!seen) begin
      waited = -1;
    end
  endtask

  task automatic receive_word(input int period, output cpu_pkg::word data, output bit ok);
    int since;  // negedges since the current start bit was seen
    int target;
    int waited;
    ok    = 1'b1;
    data  = '0;
    since = 0;
    for (int f = 0; f < uart_pkg::BYTES_PER_WORD && ok; f++) begin
      wait_start_bit((f == 0) ? START_LIMIT : FRAME_BITS * period, waited);
      if (waited < 0) begin
        $display("no start bit on tx for frame %0d", f);
        errors++;
        ok = 1'b0;
      end else begin
        if (f > 0) begin
          compare_hex("frame_spacing", FRAME_BITS * period, since + waited);
        end
        since = 0;
        for (int k = 0; k < uart_pkg::DATA_BITS + 2; k++) begin
          target = k * period + period / 2;  // mid-bit
          repeat (target - since) @(negedge clk_i);
          since = target;
          if (k == 0 && tx !== 1'b0) begin
            $display("start bit gone before mid-bit in frame %0d", f);
            errors++;
          end else if (k == uart_pkg::DATA_BITS + 1 && tx !== 1'b1) begin
            $display("framing error, stop bit low in frame %0d", f);
            errors++;
          end else if (k > 0 && k <= uart_pkg::DATA_BITS) begin
            data[f * uart_pkg::DATA_BITS + k - 1] = tx;  // lsb first
          end
        end
      end
    end
  endtask

  task automatic receive_words(input int count, input int period);
    cpu_pkg::word w;
    bit           ok;
    ok = 1'b1;
    for (int i = 0; i < count && ok; i++) begin
      receive_word(period, w, ok);
      if (ok) begin
        rx_log.push_back(w);
      end
    end
  endtask

  task automatic expect_line_quiet(input int cycles);
    logic seen_low;
    seen_low = 1'b0;
    repeat (cycles) begin
      @(negedge clk_i);
      if (tx !== 1'b1) begin
        seen_low = 1'b1;
      end
    end
    if (seen_low) begin
      $display("tx left idle after the expected words");
      errors++;
    end
  endtask

  task automatic compare_rx(input cpu_pkg::word expected [], input int count);
    if (rx_log.size() != count) begin
      $display("received %0d words on tx instead of %0d", rx_log.size(), count);
      errors++;
    end else begin
      for (int i = 0; i < count; i++) begin
        compare_hex($sformatf("tx_word[%0d]", i), expected[i], rx_log[i]);
      end
    end
  endtask

  initial begin
    cpu_pkg::word rd;
    cpu_pkg::word pv;
    cpu_pkg::word words [];
    int           errs;
    seed    = 32'h6ff0_69f8;
    reset_i = 1'b1;
    req0    = 1'b0;
    op0     = cpu_pkg::bus_read;
    addr0   = '0;
    wdata0  = '0;
    req1    = 1'b0;
    op1     = cpu_pkg::bus_read;
    addr1   = '0;
    wdata1  = '0;
    words   = new[FIFO_DEPTH + 2];
    for (int r = 0; r < ROWS; r++) begin
      row_data[r] = $random(seed);
    end
    reset_dut();

    errs = errors;
    compare_hex("tx", cpu_pkg::word'(1), cpu_pkg::word'(tx));
    compare_hex("gnt0", '0, cpu_pkg::word'(gnt0));
    compare_hex("gnt1", '0, cpu_pkg::word'(gnt1));
    bus_read(1, cpu_pkg::ADDR_STATUS, rd);
    compare_hex("status", ST_EMPTY, rd);
    finish_test("reset_state", errs);

    errs = errors;
    pv   = $random(seed);
    bus_write(0, cpu_pkg::ADDR_PRESCALE, pv);
    bus_read(1, cpu_pkg::ADDR_PRESCALE, rd);
    compare_hex("prescale", pv & PSCALE_MASK, rd);
    finish_test("prescale_rw", errs);

    for (int r = 0; r < ROWS; r++) begin
      errs = errors;
      rx_log.delete();
      wait_idle(row_port[r]);
      // upper bits are junk, only the low prescale bits count
      bus_write(row_port[r], cpu_pkg::ADDR_PRESCALE, ($random(seed) & ~PSCALE_MASK) | row_pscale[r]);
      words[0] = row_data[r];
      fork
        bus_write(row_port[r], cpu_pkg::ADDR_TXDATA, row_data[r]);
        receive_words(1, BASE_DIV << row_pscale[r]);
      join
      align_to_drive_edge();
      compare_rx(words, 1);
      finish_test($sformatf("row_%0d", r), errs);
    end

    reset_dut();
    errs = errors;
    grant_log.delete();
    rx_log.delete();
    for (int i = 0; i < 4; i++) begin
      words[i] = $random(seed);
    end
    fork
      begin
        bus_write(0, cpu_pkg::ADDR_TXDATA, words[0]);
        bus_write(0, cpu_pkg::ADDR_TXDATA, words[2]);
      end
      begin
        bus_write(1, cpu_pkg::ADDR_TXDATA, words[1]);
        bus_write(1, cpu_pkg::ADDR_TXDATA, words[3]);
      end
      receive_words(4, BASE_DIV);
    join
    align_to_drive_edge();
    if (grant_log.size() != 4) begin
      $display("saw %0d grants instead of 4", grant_log.size());
      errors++;
    end else begin
      for (int i = 0; i < 4; i++) begin
        compare_hex($sformatf("grant_port[%0d]", i), i % 2, grant_log[i]);  // 0 first
      end
    end
    compare_rx(words, 4);
    finish_test("arbitration", errs);

    reset_dut();
    errs = errors;
    rx_log.delete();
    for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
      words[i] = $random(seed);
    end
    fork
      for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
        bus_write(0, cpu_pkg::ADDR_TXDATA, words[i]);
      end
      begin
        receive_words(FIFO_DEPTH + 1, BASE_DIV);  // one in flight plus a full fifo
        expect_line_quiet(FRAME_BITS * BASE_DIV * 2);
      end
    join
    align_to_drive_edge();
    compare_rx(words, FIFO_DEPTH + 1);
    bus_read(1, cpu_pkg::ADDR_STATUS, rd);
    compare_hex("status", ST_EMPTY | ST_OVERFLOW, rd);
    bus_read(0, cpu_pkg::ADDR_STATUS, rd);
    compare_hex("status", ST_EMPTY, rd);  // overflow cleared by the first read
    finish_test("overflow", errs);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- uart_pkg.sv
// uart package: transmitter state enum and frame constants
package uart_pkg;

  localparam int BYTES_PER_WORD = 4;  // frames per fifo word
  localparam int DATA_BITS      = 8;  // 8N1
  localparam int PRESCALE_W     = 3;  // low prescale bits in use

  localparam int BIT_CNT_W  = $clog2(DATA_BITS);
  localparam int BYTE_CNT_W = $clog2(BYTES_PER_WORD);

  typedef enum logic [2:0] {
    tx_idle  = 3'd0,
    tx_start = 3'd1,
    tx_data  = 3'd2,
    tx_stop  = 3'd3,
    tx_gap   = 3'd4   // idle bit periods after a stop bit
  } tx_state_e;

endpackage

//--- uart_regs.sv
// uart_regs: txdata, prescale and status registers behind the shared i/o bus
`timescale 1ns/100ps

module uart_regs #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       bus_valid,
  input  cpu_pkg::bus_op_e           bus_op,
  input  logic [cpu_pkg::ADDR_W-1:0] bus_addr,
  input  cpu_pkg::word               bus_wdata,
  output cpu_pkg::word               bus_rdata,
  output logic                       push,
  output cpu_pkg::word               push_data,
  input  logic                       fifo_empty,
  input  logic                       fifo_full,
  input  logic                       tx_busy,
  output cpu_pkg::word               prescale
);

  logic [uart_pkg::PRESCALE_W-1:0] prescale_q;
  logic overflow;    // sticky until status read
  logic wr;
  logic rd;
  logic txdata_wr;
  logic prescale_wr;
  logic status_rd;

  // fifo pointers wrap by overflow of their width
  if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_depth_check
    $error("uart_regs: FIFO_DEPTH must be a power of two and at least 2");
  end

  always_comb begin
    wr          = bus_valid && (bus_op == cpu_pkg::bus_write);
    rd          = bus_valid && (bus_op == cpu_pkg::bus_read);
    txdata_wr   = wr && (bus_addr == cpu_pkg::ADDR_TXDATA);
    prescale_wr = wr && (bus_addr == cpu_pkg::ADDR_PRESCALE);
    status_rd   = rd && (bus_addr == cpu_pkg::ADDR_STATUS);
    push        = txdata_wr && !fifo_full;  // full drops the word
  end

  assign push_data = bus_wdata;
  assign prescale  = cpu_pkg::word'(prescale_q);

  always_comb begin
    bus_rdata = '0;
    if (rd) begin
      case (bus_addr)
        cpu_pkg::ADDR_STATUS: begin
          bus_rdata[cpu_pkg::STATUS_EMPTY]    = fifo_empty;
          bus_rdata[cpu_pkg::STATUS_FULL]     = fifo_full;
          bus_rdata[cpu_pkg::STATUS_BUSY]     = tx_busy;
          bus_rdata[cpu_pkg::STATUS_OVERFLOW] = overflow;  // pre-clear value
        end
        cpu_pkg::ADDR_PRESCALE: bus_rdata = prescale;
        default:                bus_rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prescale_q <= '0;
      overflow   <= 1'b0;
    end else begin
      if (prescale_wr) begin
        prescale_q <= bus_wdata[uart_pkg::PRESCALE_W-1:0];
      end
      if (txdata_wr && fifo_full) begin
        overflow <= 1'b1;
      end else if (status_rd) begin
        overflow <= 1'b0;
      end
    end
  end

endmodule

//--- uart_tx.sv
// uart_tx: serializes each fifo word as four 8N1 frames with a prescaled bit timer and stop gap
`timescale 1ns/100ps

module uart_tx #(
  parameter int BASE_DIV = 168,
  parameter int STOP_GAP = 10
) (
  input  logic         clk_i,
  input  logic         reset_i,
  input  cpu_pkg::word prescale,
  input  cpu_pkg::word fifo_rdata,
  input  logic         fifo_empty,
  output logic         pop,
  output logic         tx,
  output logic         busy
);

  localparam int BIT_CNT_W  = uart_pkg::BIT_CNT_W;
  localparam int BYTE_CNT_W = uart_pkg::BYTE_CNT_W;
  localparam int GAP_W      = (STOP_GAP > 1) ? $clog2(STOP_GAP) : 1;
  localparam logic [BIT_CNT_W-1:0]  BIT_LAST  = BIT_CNT_W'(uart_pkg::DATA_BITS - 1);
  localparam logic [BYTE_CNT_W-1:0] BYTE_LAST = BYTE_CNT_W'(uart_pkg::BYTES_PER_WORD - 1);
  localparam logic [GAP_W-1:0]      GAP_LAST  = GAP_W'((STOP_GAP > 0) ? STOP_GAP - 1 : 0);

  uart_pkg::tx_state_e     state;
  cpu_pkg::word            shreg;      // captured word, lsb goes next
  cpu_pkg::word            bit_timer;  // clocks into current bit
  cpu_pkg::word            bit_limit;  // clocks per bit
  logic [BIT_CNT_W-1:0]    bit_cnt;
  logic [BYTE_CNT_W-1:0]   byte_cnt;
  logic [GAP_W-1:0]        gap_cnt;
  logic                    bit_end;
  logic                    frame_end;  // last period of a frame incl. gap
  logic                    shift;

  always_comb begin
    bit_limit = cpu_pkg::word'(BASE_DIV) << prescale[uart_pkg::PRESCALE_W-1:0];
    bit_end   = (bit_timer == bit_limit - 1);
    frame_end = bit_end &&
                (((state == uart_pkg::tx_stop) && (STOP_GAP == 0)) ||
                 ((state == uart_pkg::tx_gap) && (gap_cnt == GAP_LAST)));
    shift     = bit_end &&
                ((state == uart_pkg::tx_start) ||
                 ((state == uart_pkg::tx_data) && (bit_cnt != BIT_LAST)));
    pop       = (state == uart_pkg::tx_idle) && !fifo_empty;
    busy      = (state != uart_pkg::tx_idle);
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      shreg <= fifo_rdata;
    end else if (shift) begin
      shreg <= shreg >> 1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state     <= uart_pkg::tx_idle;
      tx        <= 1'b1;
      bit_timer <= '0;
      bit_cnt   <= '0;
      byte_cnt  <= '0;
      gap_cnt   <= '0;
    end else if (pop) begin
      state     <= uart_pkg::tx_start;
      tx        <= 1'b0;  // start bit next cycle
      bit_timer <= '0;
      byte_cnt  <= '0;
    end else if (state != uart_pkg::tx_idle) begin
      if (!bit_end) begin
        bit_timer <= bit_timer + 1;
      end else begin
        bit_timer <= '0;
        if (frame_end) begin
          if (byte_cnt == BYTE_LAST) begin
            state    <= uart_pkg::tx_idle;  // line already high
            byte_cnt <= '0;
          end else begin
            byte_cnt <= byte_cnt + 1'b1;
            state    <= uart_pkg::tx_start;
            tx       <= 1'b0;
          end
        end else begin
          case (state)
            uart_pkg::tx_start: begin
              tx      <= shreg[0];
              bit_cnt <= '0;
              state   <= uart_pkg::tx_data;
            end
            uart_pkg::tx_data: begin
              if (bit_cnt == BIT_LAST) begin
                tx    <= 1'b1;  // stop bit
                state <= uart_pkg::tx_stop;
              end else begin
                tx      <= shreg[0];
                bit_cnt <= bit_cnt + 1'b1;
              end
            end
            uart_pkg::tx_stop: begin
              gap_cnt <= '0;
              state   <= uart_pkg::tx_gap;
            end
            uart_pkg::tx_gap: gap_cnt <= gap_cnt + 1'b1;
            default:          state   <= uart_pkg::tx_idle;
          endcase
        end
      end
    end
  end

endmodule

//--- uart_tx_asserts.sv
// concurrent checks on the transmitter line, pop and fifo push, with their binds
`timescale 1ns/100ps

module uart_tx_asserts (
  input logic clk_i,
  input logic reset_i,
  input logic idle,   // transmitter in tx_idle
  input logic tx,
  input logic pop,
  input logic busy,
  input logic push,
  input logic full
);

  a_idle_line_high: assert property (
    @(posedge clk_i) disable iff (reset_i) idle |-> tx
  ) else $error("tx low while the transmitter is idle");

  // a popped word keeps the transmitter busy, so no second pop can follow at once
  a_busy_after_pop: assert property (
    @(posedge clk_i) disable iff (reset_i) pop |=> busy
  ) else $error("transmitter not busy in the cycle after a pop");

  a_no_push_when_full: assert property (
    @(posedge clk_i) disable iff (reset_i) !(push && full)
  ) else $error("fifo push while full");

endmodule

// fifo inputs tied off on the transmitter side
bind uart_tx uart_tx_asserts u_tx_asserts (
  .clk_i, .reset_i, .idle(state == uart_pkg::tx_idle), .tx, .pop, .busy,
  .push(1'b0), .full(1'b0)
);

bind word_fifo uart_tx_asserts u_fifo_asserts (
  .clk_i, .reset_i, .idle(1'b0), .tx(1'b1), .pop(1'b0), .busy(1'b0), .push, .full
);

//--- word_fifo.sv
// word_fifo: synchronous circular word buffer with count-based full and empty
`timescale 1ns/100ps

module word_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         push,
  input  cpu_pkg::word wdata,
  input  logic         pop,
  output cpu_pkg::word rdata,
  output logic         empty,
  output logic         full
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = PTR_W + 1;
  localparam logic [CNT_W-1:0] FULL_COUNT = FIFO_DEPTH[CNT_W-1:0];

  cpu_pkg::word     mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // words held
  logic             do_push;
  logic             do_pop;

  assign empty   = (count == '0);
  assign full    = (count == FULL_COUNT);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign rdata   = mem[rd_ptr];  // head word, valid while !empty

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule
